// ==== common/fpu_cfg.svh ====
// fpu configuration
// tag width, lane count and binary32 format constants
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

`define FPU_TAG_W   4
`define FPU_LANES   2

// binary32 format
`define FP_EXP_BIAS 127
`define FP_EXP_MAX  255
`define FP_QNAN     32'h7fc00000

`endif

// ==== common/fpu_pkg.sv ====
// fpu package
// types shared by the binary32 multiply lanes, the arbiter and the testbench
package fpu_pkg;

  // IEEE rounding directions
  typedef enum logic [1:0] {
    RNE = 2'd0,
    RTZ = 2'd1,
    RUP = 2'd2,
    RDN = 2'd3
  } round_mode_e;

  // operand classes, denormals fold into ZERO
  typedef enum logic [2:0] {
    ZERO   = 3'd0,
    NORMAL = 3'd1,
    INF    = 3'd2,
    NAN    = 3'd3
  } fp_class_e;

  // exception flags reported with every result
  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fpu_flags_t;

endpackage

// ==== common/fpu_result_if.sv ====
// fpu result channel
// carries one lane's finished result toward the shared result bus
`include "fpu_cfg.svh"

interface fpu_result_if import fpu_pkg::*; ();

  logic                  req;
  logic                  gnt;
  logic [`FPU_TAG_W-1:0] tag;
  logic [31:0]           data;
  fpu_flags_t            flags;

  modport lane (
    output req, tag, data, flags,
    input  gnt
  );

  modport arb (
    input  req, tag, data, flags,
    output gnt
  );

endinterface

// ==== fmul/fmul_classify.sv ====
// fmul operand classifier
// decodes both operands and picks the result for zero, infinity and NaN cases
`include "fpu_cfg.svh"

module fmul_classify import fpu_pkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  output fp_class_e   class_a,
  output fp_class_e   class_b,
  output logic        special,
  output logic [31:0] special_res,
  output logic        invalid
);

  logic sign;
  logic any_nan;
  logic any_inf;
  logic inf_zero;

  function automatic fp_class_e decode(input logic [31:0] x);
    // zero exponent covers denormals too
    if (x[30:23] == 8'd0) begin
      return ZERO;
    end
    if (x[30:23] == 8'(`FP_EXP_MAX)) begin
      return (x[22:0] == 23'd0) ? INF : NAN;
    end
    return NORMAL;
  endfunction

  assign class_a = decode(a);
  assign class_b = decode(b);
  assign sign    = a[31] ^ b[31];

  assign any_nan  = (class_a == NAN) || (class_b == NAN);
  assign any_inf  = (class_a == INF) || (class_b == INF);
  assign inf_zero = ((class_a == INF) && (class_b == ZERO)) ||
                    ((class_a == ZERO) && (class_b == INF));

  assign special = (class_a != NORMAL) || (class_b != NORMAL);
  assign invalid = inf_zero;

  always_comb begin
    if (any_nan || inf_zero) begin
      special_res = `FP_QNAN;
    end else if (any_inf) begin
      special_res = {sign, 8'hff, 23'd0};
    end else begin
      special_res = {sign, 31'd0};
    end
  end

endmodule

// ==== fmul/fmul_lane.sv ====
// fmul lane
// three-stage binary32 multiply pipeline: classify, multiply, round
// the last stage feeds a hold register that requests the shared result bus
`include "fpu_cfg.svh"

module fmul_lane import fpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  logic [31:0]           a,
  input  logic [31:0]           b,
  input  round_mode_e           rmode,
  input  logic [`FPU_TAG_W-1:0] tag,
  output logic                  stall,
  fpu_result_if.lane            res
);

  fp_class_e             class_a;
  fp_class_e             class_b;
  logic                  special_c;
  logic [31:0]           special_res_c;
  logic                  invalid_c;
  logic                  advance;

  // stage 1
  logic                  v1;
  logic                  sign1;
  logic signed [9:0]     exp1;
  logic [23:0]           siga1;
  logic [23:0]           sigb1;
  logic                  special1;
  logic [31:0]           spres1;
  logic                  inv1;
  round_mode_e           rmode1;
  logic [`FPU_TAG_W-1:0] tag1;

  // stage 2
  logic                  v2;
  logic                  sign2;
  logic signed [9:0]     exp2;
  logic [47:0]           prod2;
  logic                  special2;
  logic [31:0]           spres2;
  logic                  inv2;
  round_mode_e           rmode2;
  logic [`FPU_TAG_W-1:0] tag2;

  logic [31:0]           rnd_res;
  fpu_flags_t            rnd_flags;

  // hold register
  logic                  hold_v;
  logic [31:0]           hold_data;
  fpu_flags_t            hold_flags;
  logic [`FPU_TAG_W-1:0] hold_tag;

  fmul_classify u_classify (
    .a           (a),
    .b           (b),
    .class_a     (class_a),
    .class_b     (class_b),
    .special     (special_c),
    .special_res (special_res_c),
    .invalid     (invalid_c)
  );

  fmul_round u_round (
    .sign    (sign2),
    .exp_sum (exp2),
    .prod    (prod2),
    .rmode   (rmode2),
    .res     (rnd_res),
    .flags   (rnd_flags)
  );

  // full hold register waiting for the bus freezes everything
  assign stall   = hold_v & ~res.gnt;
  assign advance = ~stall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1     <= 1'b0;
      v2     <= 1'b0;
      hold_v <= 1'b0;
    end else if (advance) begin
      v1     <= issue;
      v2     <= v1;
      hold_v <= v2;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      sign1    <= a[31] ^ b[31];
      exp1     <= {2'b00, a[30:23]} + {2'b00, b[30:23]};
      siga1    <= {class_a == NORMAL, a[22:0]};
      sigb1    <= {class_b == NORMAL, b[22:0]};
      special1 <= special_c;
      spres1   <= special_res_c;
      inv1     <= invalid_c;
      rmode1   <= rmode;
      tag1     <= tag;

      sign2    <= sign1;
      exp2     <= exp1;
      prod2    <= siga1 * sigb1;
      special2 <= special1;
      spres2   <= spres1;
      inv2     <= inv1;
      rmode2   <= rmode1;
      tag2     <= tag1;

      hold_tag <= tag2;
      if (special2) begin
        hold_data  <= spres2;
        hold_flags <= '{invalid: inv2, overflow: 1'b0, underflow: 1'b0, inexact: 1'b0};
      end else begin
        hold_data  <= rnd_res;
        hold_flags <= rnd_flags;
      end
    end
  end

  assign res.req   = hold_v;
  assign res.tag   = hold_tag;
  assign res.data  = hold_data;
  assign res.flags = hold_flags;

  // issuing into a stalled lane would drop the operation
  a_no_issue_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |-> !issue);

  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    res.req && !res.gnt |=> res.req && $stable(res.tag) && $stable(res.data));

endmodule

// ==== fmul/fmul_round.sv ====
// fmul normalize and round
// takes the raw significand product and biased exponent sum, rounds in
// one of four modes and handles overflow and flush to zero
`include "fpu_cfg.svh"

module fmul_round import fpu_pkg::*; (
  input  logic              sign,
  input  logic signed [9:0] exp_sum,
  input  logic [47:0]       prod,
  input  round_mode_e       rmode,
  output logic [31:0]       res,
  output fpu_flags_t        flags
);

  logic [22:0]       mant;
  logic              guard;
  logic              sticky;
  logic              round_up;
  logic              carry;
  logic [23:0]       mant_rnd;
  logic signed [9:0] exp_norm;
  logic signed [9:0] exp_fin;
  logic              ovf;
  logic              unf;
  logic              max_finite;

  // product of two 1.x values lies in [1,4)
  always_comb begin
    if (prod[47]) begin
      mant     = prod[46:24];
      guard    = prod[23];
      sticky   = |prod[22:0];
      exp_norm = 10'(exp_sum - `FP_EXP_BIAS + 1);
    end else begin
      mant     = prod[45:23];
      guard    = prod[22];
      sticky   = |prod[21:0];
      exp_norm = 10'(exp_sum - `FP_EXP_BIAS);
    end
  end

  always_comb begin
    case (rmode)
      RNE:     round_up = guard & (sticky | mant[0]);
      RTZ:     round_up = 1'b0;
      RUP:     round_up = ~sign & (guard | sticky);
      default: round_up = sign & (guard | sticky);
    endcase
  end

  // carry out leaves a zero fraction, only the exponent moves
  assign mant_rnd = {1'b0, mant} + {23'd0, round_up};
  assign carry    = mant_rnd[23];
  assign exp_fin  = exp_norm + $signed({9'd0, carry});

  assign ovf = exp_fin >= `FP_EXP_MAX;
  assign unf = exp_fin < 1;

  // directed modes that point away from the sign saturate
  always_comb begin
    case (rmode)
      RTZ:     max_finite = 1'b1;
      RUP:     max_finite = sign;
      RDN:     max_finite = ~sign;
      default: max_finite = 1'b0;
    endcase
  end

  always_comb begin
    if (ovf) begin
      res = max_finite ? {sign, 8'hfe, 23'h7fffff} : {sign, 8'hff, 23'd0};
    end else if (unf) begin
      res = {sign, 31'd0};
    end else begin
      res = {sign, exp_fin[7:0], mant_rnd[22:0]};
    end
  end

  assign flags.invalid   = 1'b0;
  assign flags.overflow  = ovf;
  assign flags.underflow = unf;
  assign flags.inexact   = guard | sticky | ovf | unf;

endmodule

// ==== logic/fpu_mul_top.sv ====
// fpu multiply top
// two binary32 multiply lanes sharing one result bus through an arbiter
`include "fpu_cfg.svh"

module fpu_mul_top import fpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  a_issue,
  input  logic [31:0]           a_op_a,
  input  logic [31:0]           a_op_b,
  input  round_mode_e           a_rmode,
  input  logic [`FPU_TAG_W-1:0] a_tag,
  output logic                  a_stall,

  input  logic                  b_issue,
  input  logic [31:0]           b_op_a,
  input  logic [31:0]           b_op_b,
  input  round_mode_e           b_rmode,
  input  logic [`FPU_TAG_W-1:0] b_tag,
  output logic                  b_stall,

  output logic                  res_valid,
  output logic                  res_lane,
  output logic [`FPU_TAG_W-1:0] res_tag,
  output logic [31:0]           res_data,
  output fpu_flags_t            res_flags
);

  fpu_result_if res_if [`FPU_LANES] ();

  fmul_lane u_lane_a (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (a_issue),
    .a     (a_op_a),
    .b     (a_op_b),
    .rmode (a_rmode),
    .tag   (a_tag),
    .stall (a_stall),
    .res   (res_if[0])
  );

  fmul_lane u_lane_b (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (b_issue),
    .a     (b_op_a),
    .b     (b_op_b),
    .rmode (b_rmode),
    .tag   (b_tag),
    .stall (b_stall),
    .res   (res_if[1])
  );

  result_arbiter u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .lane0     (res_if[0]),
    .lane1     (res_if[1]),
    .res_valid (res_valid),
    .res_lane  (res_lane),
    .res_tag   (res_tag),
    .res_data  (res_data),
    .res_flags (res_flags)
  );

endmodule

// ==== logic/result_arbiter.sv ====
// result arbiter
// round-robin grant of the shared result bus between the two lanes
`include "fpu_cfg.svh"

module result_arbiter import fpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  fpu_result_if.arb             lane0,
  fpu_result_if.arb             lane1,
  output logic                  res_valid,
  output logic                  res_lane,
  output logic [`FPU_TAG_W-1:0] res_tag,
  output logic [31:0]           res_data,
  output fpu_flags_t            res_flags
);

  logic [`FPU_LANES-1:0] req;
  logic [`FPU_LANES-1:0] gnt;
  // lane index of the most recent grant
  logic                  last_gnt;

  assign req = {lane1.req, lane0.req};

  // on a tie the lane not served last wins
  assign gnt[0] = req[0] & (~req[1] | last_gnt);
  assign gnt[1] = req[1] & (~req[0] | ~last_gnt);

  assign lane0.gnt = gnt[0];
  assign lane1.gnt = gnt[1];

  assign res_valid = |gnt;
  assign res_lane  = gnt[1];
  assign res_tag   = res_lane ? lane1.tag : lane0.tag;
  assign res_data  = res_lane ? lane1.data : lane0.data;
  assign res_flags = res_lane ? lane1.flags : lane0.flags;

  // points at lane 1 out of reset so lane 0 takes the first tie
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_gnt <= 1'b1;
    end else if (res_valid) begin
      last_gnt <= res_lane;
    end
  end

  a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(gnt));

  // a lane left waiting takes the bus in the next cycle
  a_wait_served: assert property (@(posedge clk) disable iff (!rst_n)
    (req & ~gnt) != '0 |=> gnt == $past(req & ~gnt));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fpu multiply testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_fpu_mul -o sim_tb_fpu_mul

# the simulator exits nonzero on a fatal check, the log decides the verdict
./obj_dir/sim_tb_fpu_mul > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "\*\*\* PASSED \*\*\*" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
exit 0

// ==== tb.f ====
+incdir+common
common/fpu_pkg.sv
common/fpu_result_if.sv
fmul/fmul_classify.sv
fmul/fmul_round.sv
fmul/fmul_lane.sv
logic/result_arbiter.sv
logic/fpu_mul_top.sv
tb/tb_fpu_mul.sv

// ==== tb/tb_fpu_mul.sv ====
// testbench for the two-lane binary32 multiply unit
// directed tests with a scoreboard fed by a reference multiply model
`include "fpu_cfg.svh"

module tb_fpu_mul import fpu_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYC  = 16;
  // operations over all tests, with ten cycles allowed for each
  localparam int N_OPS      = 241;
  localparam int LIMIT      = (N_OPS * 10 + 2 * RESET_CYC) * CLK_PERIOD;

  logic                  clk;
  logic                  rst_n;
  logic                  a_issue;
  logic [31:0]           a_op_a;
  logic [31:0]           a_op_b;
  round_mode_e           a_rmode;
  logic [`FPU_TAG_W-1:0] a_tag;
  logic                  a_stall;
  logic                  b_issue;
  logic [31:0]           b_op_a;
  logic [31:0]           b_op_b;
  round_mode_e           b_rmode;
  logic [`FPU_TAG_W-1:0] b_tag;
  logic                  b_stall;
  logic                  res_valid;
  logic                  res_lane;
  logic [`FPU_TAG_W-1:0] res_tag;
  logic [31:0]           res_data;
  fpu_flags_t            res_flags;

  // scoreboard state, ops are {a, b, mode}
  logic [65:0]           pend [2][$];
  logic [`FPU_TAG_W-1:0] order_q [2][$];
  logic [35:0]           exp_res [2][1 << `FPU_TAG_W];
  int                    issue_cyc [2][1 << `FPU_TAG_W];
  logic [`FPU_TAG_W-1:0] tag_cnt [2];
  logic                  lane_log [$];
  logic                  v1 [2];
  logic                  v2 [2];
  logic                  drv_issue [2];
  logic                  go [2];
  int                    outstanding;
  int                    cycle;
  logic [31:0]           seed;
  logic [31:0]           last_data;
  logic [3:0]            last_flags;
  int                    last_lat;

  fpu_mul_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    #(LIMIT);
    $display("watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

  task automatic abort(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "abort");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [31:0] rand_normal();
    logic [31:0] r;
    logic [31:0] f;
    r = lcg_next();
    f = lcg_next();
    // exponent kept in 64..191 so most products stay normal
    return {r[31], 8'd64 + {1'b0, r[30:24]}, f[22:0]};
  endfunction

  // returns {invalid, overflow, underflow, inexact, data}
  function automatic logic [35:0] ref_mul(input logic [31:0] a, input logic [31:0] b,
                                          input logic [1:0] m);
    logic            za, zb, ia, ib, na, nb, s, inc, sat;
    int              e;
    longint unsigned p, keep, rem, half;
    logic [3:0]      f;
    logic [31:0]     d;
    s  = a[31] ^ b[31];
    za = a[30:23] == 8'd0;
    zb = b[30:23] == 8'd0;
    ia = a[30:23] == 8'hff && a[22:0] == 23'd0;
    ib = b[30:23] == 8'hff && b[22:0] == 23'd0;
    na = a[30:23] == 8'hff && a[22:0] != 23'd0;
    nb = b[30:23] == 8'hff && b[22:0] != 23'd0;
    f  = 4'd0;
    if (na || nb || (ia && zb) || (za && ib)) begin
      d    = 32'h7fc00000;
      f[3] = (ia && zb) || (za && ib);
    end else if (ia || ib) begin
      d = {s, 8'hff, 23'd0};
    end else if (za || zb) begin
      d = {s, 31'd0};
    end else begin
      p = {40'd0, 1'b1, a[22:0]} * {40'd0, 1'b1, b[22:0]};
      e = int'(a[30:23]) + int'(b[30:23]) - 127;
      if (p[47]) begin
        keep = p >> 24;
        rem  = p & 64'hffffff;
        half = 64'h800000;
        e    = e + 1;
      end else begin
        keep = p >> 23;
        rem  = p & 64'h7fffff;
        half = 64'h400000;
      end
      case (m)
        2'd0:    inc = (rem > half) || (rem == half && keep[0]);
        2'd1:    inc = 1'b0;
        2'd2:    inc = !s && rem != 0;
        default: inc = s && rem != 0;
      endcase
      keep = keep + {63'd0, inc};
      if (keep == 64'h1000000) begin
        keep = 64'h800000;
        e    = e + 1;
      end
      f[0] = rem != 0;
      if (e >= 255) begin
        sat  = (m == 2'd1) || (m == 2'd2 && s) || (m == 2'd3 && !s);
        d    = sat ? {s, 31'h7f7fffff} : {s, 31'h7f800000};
        f[2] = 1'b1;
        f[0] = 1'b1;
      end else if (e < 1) begin
        d    = {s, 31'd0};
        f[1] = 1'b1;
        f[0] = 1'b1;
      end else begin
        d = {s, e[7:0], keep[22:0]};
      end
    end
    return {f, d};
  endfunction

  task automatic drive_port(input int l, input logic iss, input logic [65:0] op,
                            input logic [`FPU_TAG_W-1:0] t);
    if (l == 0) begin
      a_issue <= iss;
      a_op_a  <= op[65:34];
      a_op_b  <= op[33:2];
      a_rmode <= round_mode_e'(op[1:0]);
      a_tag   <= t;
    end else begin
      b_issue <= iss;
      b_op_a  <= op[65:34];
      b_op_b  <= op[33:2];
      b_rmode <= round_mode_e'(op[1:0]);
      b_tag   <= t;
    end
  endtask

  // lane drivers; issue only when the lane will not stall in the next cycle
  initial begin
    logic [65:0] op;
    logic        st;
    forever begin
      @(negedge clk);
      for (int l = 0; l < 2; l++) begin
        st    = (l == 0) ? a_stall : b_stall;
        go[l] = rst_n && pend[l].size() > 0 && !st && !v2[l];
        if (!rst_n) begin
          v1[l] = 1'b0;
          v2[l] = 1'b0;
        end else if (!st) begin
          v2[l] = v1[l];
          v1[l] = drv_issue[l];
        end
      end
      @(posedge clk);
      for (int l = 0; l < 2; l++) begin
        drv_issue[l] = go[l];
        if (go[l]) begin
          op = pend[l].pop_front();
          exp_res[l][tag_cnt[l]]   = ref_mul(op[65:34], op[33:2], op[1:0]);
          issue_cyc[l][tag_cnt[l]] = cycle + 1;
          order_q[l].push_back(tag_cnt[l]);
          outstanding = outstanding + 1;
          drive_port(l, 1'b1, op, tag_cnt[l]);
          tag_cnt[l] = tag_cnt[l] + 1'b1;
        end else begin
          drive_port(l, 1'b0, 66'd0, '0);
        end
      end
    end
  end

  // result monitor
  always @(negedge clk) begin
    logic [`FPU_TAG_W-1:0] t;
    logic [35:0]           e;
    if (rst_n && ((a_issue && a_stall) || (b_issue && b_stall))) begin
      abort("issue driven while the lane was stalled");
    end
    if (rst_n && res_valid) begin
      if (order_q[res_lane].size() == 0) begin
        abort("result arrived with no operation outstanding on its lane");
      end
      t = order_q[res_lane].pop_front();
      check("res_tag", {28'd0, res_tag}, {28'd0, t});
      e = exp_res[res_lane][t];
      check("res_data", res_data, e[31:0]);
      check("res_flags", {28'd0, res_flags}, {28'd0, e[35:32]});
      last_data   = res_data;
      last_flags  = res_flags;
      last_lat    = cycle - issue_cyc[res_lane][t];
      lane_log.push_back(res_lane);
      outstanding = outstanding - 1;
    end
  end

  task automatic push_op(input int l, input logic [31:0] a, input logic [31:0] b,
                         input logic [1:0] m);
    pend[l].push_back({a, b, m});
  endtask

  task automatic wait_idle();
    while (pend[0].size() > 0 || pend[1].size() > 0 || outstanding != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
  endtask

  task automatic run_check(input logic [31:0] a, input logic [31:0] b, input logic [1:0] m,
                           input logic [31:0] d, input logic [3:0] f, input logic lat3);
    push_op(0, a, b, m);
    wait_idle();
    check("res_data", last_data, d);
    check("res_flags", {28'd0, last_flags}, {28'd0, f});
    if (lat3) begin
      check("latency", last_lat, 32'd3);
    end
  endtask

  task automatic test_exact();
    for (int m = 0; m < 4; m++) begin
      run_check(32'h40400000, 32'h40a00000, 2'(m), 32'h41700000, 4'h0, 1'b1);
      run_check(32'h40e00000, 32'hc0800000, 2'(m), 32'hc1e00000, 4'h0, 1'b1);
      run_check(32'h40000000, 32'h40400000, 2'(m), 32'h40c00000, 4'h0, 1'b1);
    end
  endtask

  task automatic test_random_round();
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < 8; i++) begin
        push_op(0, rand_normal(), rand_normal(), 2'(m));
        push_op(1, rand_normal(), rand_normal(), 2'(m));
      end
    end
    wait_idle();
  endtask

  task automatic test_special();
    run_check(32'h00000000, 32'h40400000, 2'd0, 32'h00000000, 4'h0, 1'b0);
    run_check(32'h80000000, 32'h40400000, 2'd0, 32'h80000000, 4'h0, 1'b0);
    run_check(32'h7f800000, 32'h40000000, 2'd1, 32'h7f800000, 4'h0, 1'b0);
    run_check(32'hff800000, 32'h40000000, 2'd2, 32'hff800000, 4'h0, 1'b0);
    run_check(32'h7f800000, 32'h00000000, 2'd0, 32'h7fc00000, 4'h8, 1'b0);
    run_check(32'h7fc00000, 32'h3f800000, 2'd0, 32'h7fc00000, 4'h0, 1'b0);
    // denormal input counts as zero
    run_check(32'h00400000, 32'hc0000000, 2'd3, 32'h80000000, 4'h0, 1'b0);
    run_check(32'h80400000, 32'h7f800000, 2'd0, 32'h7fc00000, 4'h8, 1'b0);
  endtask

  task automatic test_range();
    run_check(32'h7f000000, 32'h7f000000, 2'd0, 32'h7f800000, 4'h5, 1'b0);
    run_check(32'hff000000, 32'h7f000000, 2'd0, 32'hff800000, 4'h5, 1'b0);
    run_check(32'h7f000000, 32'h7f000000, 2'd1, 32'h7f7fffff, 4'h5, 1'b0);
    run_check(32'hff000000, 32'h7f000000, 2'd1, 32'hff7fffff, 4'h5, 1'b0);
    run_check(32'h7f000000, 32'h7f000000, 2'd2, 32'h7f800000, 4'h5, 1'b0);
    run_check(32'hff000000, 32'h7f000000, 2'd2, 32'hff7fffff, 4'h5, 1'b0);
    run_check(32'h7f000000, 32'h7f000000, 2'd3, 32'h7f7fffff, 4'h5, 1'b0);
    run_check(32'hff000000, 32'h7f000000, 2'd3, 32'hff800000, 4'h5, 1'b0);
    for (int m = 0; m < 4; m++) begin
      run_check(32'h00800000, 32'h00800000, 2'(m), 32'h00000000, 4'h3, 1'b0);
      run_check(32'h80800000, 32'h00800000, 2'(m), 32'h80000000, 4'h3, 1'b0);
    end
  endtask

  task automatic tie_round(input logic first_lane);
    lane_log.delete();
    push_op(0, rand_normal(), rand_normal(), 2'd0);
    push_op(1, rand_normal(), rand_normal(), 2'd0);
    wait_idle();
    check("tie_lane0", {31'd0, lane_log[0]}, {31'd0, first_lane});
    check("tie_lane1", {31'd0, lane_log[1]}, {31'd0, ~first_lane});
  endtask

  task automatic test_contention();
    int n0;
    apply_reset();
    // lane 0 takes the first tie after reset
    tie_round(1'b0);
    // a lone lane 0 result hands the next tie to lane 1
    push_op(0, rand_normal(), rand_normal(), 2'd0);
    wait_idle();
    tie_round(1'b1);
    lane_log.delete();
    for (int i = 0; i < 8; i++) begin
      push_op(0, rand_normal(), rand_normal(), 2'(i));
      push_op(1, rand_normal(), rand_normal(), 2'(i));
    end
    wait_idle();
    n0 = 0;
    foreach (lane_log[i]) n0 += lane_log[i] ? 0 : 1;
    check("result_count", lane_log.size(), 32'd16);
    check("lane0_count", n0, 32'd8);
  endtask

  task automatic test_sustained();
    lane_log.delete();
    for (int i = 0; i < 60; i++) begin
      push_op(0, rand_normal(), rand_normal(), 2'(lcg_next() >> 30));
      push_op(1, rand_normal(), rand_normal(), 2'(lcg_next() >> 30));
    end
    wait_idle();
    check("result_count", lane_log.size(), 32'd120);
  endtask

  initial begin
    rst_n       = 1'b0;
    a_issue     = 1'b0;
    a_op_a      = '0;
    a_op_b      = '0;
    a_rmode     = RNE;
    a_tag       = '0;
    b_issue     = 1'b0;
    b_op_a      = '0;
    b_op_b      = '0;
    b_rmode     = RNE;
    b_tag       = '0;
    seed        = 32'd45;
    cycle       = 0;
    outstanding = 0;
    for (int l = 0; l < 2; l++) begin
      tag_cnt[l]   = '0;
      v1[l]        = 1'b0;
      v2[l]        = 1'b0;
      drv_issue[l] = 1'b0;
    end
    apply_reset();
    test_exact();
    test_random_round();
    test_special();
    test_range();
    test_contention();
    test_sustained();
    $display("*** PASSED ***");
    $finish;
  end

endmodule
